/* source/xbus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Xbus definitions: word types, request and response
// structs, the address map and the no-response timeout
// ~~~~~~~~~~~~~~~~~~~~
package xbus_pkg;

   localparam int ADDR_BITS = 22;  // Word address width
   localparam int WORD_BITS = 32;  // Data word width

   typedef logic [ADDR_BITS-1:0] xbus_addr_t;
   typedef logic [WORD_BITS-1:0] xbus_word_t;

   // Held stable by the master while req is high
   typedef struct packed {
      xbus_addr_t addr;
      xbus_word_t wdata;
      logic       write;  // High for a write, low for a read
   } xbus_req_t;

   typedef struct packed {
      logic       ack;    // Request is done
      logic       err;    // No responder decoded the request
      xbus_word_t rdata;  // Valid while ack is high
   } xbus_rsp_t;

   // Scratch memory at the bottom of the address space
   localparam xbus_addr_t RAM_BASE      = 22'o0;
   localparam int         RAM_WORDS     = 256;
   localparam int         RAM_ADDR_BITS = 8;

   // Unibus control block and the two windows it acknowledges only
   localparam xbus_addr_t UNIBUS_BASE        = 22'o17773000;
   localparam int         UNIBUS_WINDOW_BITS = 6;  // 64 words
   localparam xbus_addr_t OTHER_BASE_A       = 22'o17777700;
   localparam int         OTHER_A_BITS       = 6;  // 64 words
   localparam xbus_addr_t OTHER_BASE_B       = 22'o17740000;
   localparam int         OTHER_B_BITS       = 12; // 4096 words

   // Timed out addresses above these limits set a no-response status bit
   localparam xbus_addr_t UNIBUS_NXM_LIMIT = 22'o17400000;
   localparam xbus_addr_t XBUS_NXM_LIMIT   = 22'o17000000;

   // Undecoded request cycles before the watchdog answers
   localparam int TIMEOUT_CYCLES = 16;
   localparam int TIMEOUT_BITS   = $clog2(TIMEOUT_CYCLES + 1);

endpackage

/* source/unibus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Unibus control block register offsets and the
// layouts of its interrupt and status registers
// ~~~~~~~~~~~~~~~~~~~~
package unibus_pkg;

   typedef logic [5:0] unibus_ofs_t;  // Word offset inside the 64-word window

   localparam unibus_ofs_t PROM_CTRL_OFS  = 6'o05;
   localparam unibus_ofs_t BUS_INTS_OFS   = 6'o20;
   localparam unibus_ofs_t BUS_STATUS_OFS = 6'o22;

   // Bit 5 and bit 2 set with bit 0 clear disables the boot PROM
   localparam logic [5:0] PROM_KEY_MASK    = 6'b100101;
   localparam logic [5:0] PROM_DISABLE_KEY = 6'b100100;

   localparam int INT_EN_BIT = 10;  // Interrupt enable in a bus_ints write

   typedef struct packed {
      logic [15:0] zero_hi;
      logic        unibus_int;  // Pending unibus interrupt
      logic        xbus_int;    // Pending xbus interrupt
      logic [2:0]  zero_mid;
      logic        int_en;
      logic [7:0]  vector;
      logic [1:0]  zero_lo;
   } bus_ints_t;

   typedef struct packed {
      logic [27:0] zero_hi;
      logic        unibus_nxm;  // A unibus address timed out
      logic [1:0]  zero_mid;
      logic        xbus_nxm;    // An xbus address timed out
   } bus_status_t;

endpackage

/* source/xbus_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Scratch memory responder of 256 words at the bottom
// of the address space, acknowledged two edges after decode
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xbus_ram import xbus_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       req,
   input  xbus_req_t  cmd,
   output logic       decode,
   output logic       ack,
   output xbus_word_t rdata
);

   xbus_word_t               mem [RAM_WORDS];
   logic [RAM_ADDR_BITS-1:0] idx;
   logic [1:0]               ack_sr;
   logic                     first;
   xbus_word_t               rdata_q;

   assign decode = req && ((cmd.addr >> RAM_ADDR_BITS) == (RAM_BASE >> RAM_ADDR_BITS));
   assign idx    = cmd.addr[RAM_ADDR_BITS-1:0];
   assign first  = decode & ~ack_sr[0];  // First edge of a decoded request

   always_ff @(posedge clk)
   begin
      if (reset)
         ack_sr <= '0;
      else
         ack_sr <= {ack_sr[0], decode};
   end

   assign ack = ack_sr[1];

   always_ff @(posedge clk)
   begin
      if (first && cmd.write)
         mem[idx] <= cmd.wdata;
      if (decode)
         rdata_q <= mem[idx];
   end

   assign rdata = ack ? rdata_q : '0;

   // The master holds the request for the whole decode
   addr_stable: assert property (@(posedge clk) disable iff (reset)
      decode && $past(decode) |-> $stable(cmd.addr));

endmodule

/* source/xbus_unibus.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Unibus control block. Decodes its window and the spy/mode
// windows, acknowledges two edges after decode and keeps the
// interrupt enable, no-response status and PROM disable
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xbus_unibus import xbus_pkg::*, unibus_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       req,
   input  xbus_req_t  cmd,
   input  logic       timeout,      // One-cycle pulse from the watchdog
   output logic       decode,
   output logic       ack,
   output xbus_word_t rdata,
   output logic       promdisable
);

   logic        in_unibus;
   logic        in_other;
   logic        decode_unibus;
   logic        decode_other;
   logic        wr_unibus;
   unibus_ofs_t offset;
   logic [1:0]  ack_sr;
   logic        int_en;
   logic        unibus_nxm;
   logic        xbus_nxm;
   bus_ints_t   ints_word;
   bus_status_t status_word;
   xbus_word_t  read_word;
   xbus_word_t  rdata_q;

   assign in_unibus = (cmd.addr >> UNIBUS_WINDOW_BITS) == (UNIBUS_BASE >> UNIBUS_WINDOW_BITS);
   assign in_other  = ((cmd.addr >> OTHER_A_BITS) == (OTHER_BASE_A >> OTHER_A_BITS)) ||
                      ((cmd.addr >> OTHER_B_BITS) == (OTHER_BASE_B >> OTHER_B_BITS));

   assign decode_unibus = req & in_unibus;
   assign decode_other  = req & in_other;   // Acknowledged, reads return zero
   assign decode        = decode_unibus | decode_other;
   assign wr_unibus     = decode_unibus & cmd.write;
   assign offset        = cmd.addr[UNIBUS_WINDOW_BITS-1:0];

   always_ff @(posedge clk)
   begin
      if (reset)
         ack_sr <= '0;
      else
         ack_sr <= {ack_sr[0], decode};
   end

   assign ack = ack_sr[1];

   // Pending interrupt bits and the vector stay zero since nothing here raises an interrupt
   always_comb
   begin
      ints_word          = '0;
      ints_word.int_en   = int_en;
      status_word            = '0;
      status_word.unibus_nxm = unibus_nxm;
      status_word.xbus_nxm   = xbus_nxm;
   end

   always_comb
   begin
      read_word = '0;
      if (decode_unibus && !cmd.write)
      begin
         case (offset)
            BUS_INTS_OFS:   read_word = ints_word;
            BUS_STATUS_OFS: read_word = status_word;
            default:        read_word = '0;  // Unused offsets read zero
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (decode)
         rdata_q <= read_word;
   end

   assign rdata = ack ? rdata_q : '0;  // Zero outside ack so the top can OR

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         promdisable <= 1'b0;
         int_en      <= 1'b0;
      end
      else
      begin
         promdisable <= wr_unibus && (offset == PROM_CTRL_OFS) &&
                        ((cmd.wdata[5:0] & PROM_KEY_MASK) == PROM_DISABLE_KEY);
         if (wr_unibus && (offset == BUS_INTS_OFS))
         begin
            int_en <= cmd.wdata[INT_EN_BIT];  // Set or clear from the written bit
         end
      end
   end

   // A timeout takes priority over a status clear in the same cycle
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         unibus_nxm <= 1'b0;
         xbus_nxm   <= 1'b0;
      end
      else if (timeout)
      begin
         if (cmd.addr > UNIBUS_NXM_LIMIT)
            unibus_nxm <= 1'b1;
         else if (cmd.addr > XBUS_NXM_LIMIT)
            xbus_nxm <= 1'b1;
      end
      else if (wr_unibus && (offset == BUS_STATUS_OFS))
      begin
         unibus_nxm <= 1'b0;
         xbus_nxm   <= 1'b0;
      end
   end

   // The acknowledge needs a decode held over both stages
   ack_follows_decode: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> $past(decode, 2) && $past(decode));

endmodule

/* source/xbus_timeout.sv */
// ~~~~~~~~~~~~~~~~~~~~
// No-response watchdog. Counts request cycles that nothing
// decodes, then reports the timeout and completes the request
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xbus_timeout import xbus_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic req,
   input  logic any_decode,  // OR of all responder decodes
   output logic ack,
   output logic timeout
);

   logic [TIMEOUT_BITS-1:0] count;
   logic                    hit;
   logic                    expired;
   logic [1:0]              ack_sr;

   assign hit     = req && !any_decode && (count == TIMEOUT_BITS'(TIMEOUT_CYCLES - 1));
   assign expired = (count == TIMEOUT_BITS'(TIMEOUT_CYCLES));  // Count saturates here

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count   <= '0;
         timeout <= 1'b0;
         ack_sr  <= '0;
      end
      else
      begin
         timeout <= hit;
         if (!req)
            count <= '0;
         else if (!any_decode && !expired)
            count <= count + 1'b1;
         ack_sr <= {ack_sr[0], req & expired};  // Held while req stays high
      end
   end

   assign ack = ack_sr[1];

   single_pulse: assert property (@(posedge clk) disable iff (reset)
      timeout |=> !timeout);

   // A decoded request is never answered by the watchdog
   no_ack_on_decode: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> !any_decode);

endmodule

/* source/xbus_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Xbus slice top level. Joins the responders
// and merges ack, read data and error
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xbus_top import xbus_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      req,
   input  xbus_req_t cmd,
   output xbus_rsp_t rsp,
   output logic      promdisable
);

   logic       ram_decode;
   logic       ram_ack;
   xbus_word_t ram_rdata;
   logic       uni_decode;
   logic       uni_ack;
   xbus_word_t uni_rdata;
   logic       to_ack;
   logic       to_pulse;
   logic       any_decode;

   xbus_ram xbus_ram_inst (
      .clk(clk), .reset(reset), .req(req), .cmd(cmd),
      .decode(ram_decode), .ack(ram_ack), .rdata(ram_rdata)
   );

   xbus_unibus xbus_unibus_inst (
      .clk(clk), .reset(reset), .req(req), .cmd(cmd), .timeout(to_pulse),
      .decode(uni_decode), .ack(uni_ack), .rdata(uni_rdata), .promdisable(promdisable)
   );

   xbus_timeout xbus_timeout_inst (
      .clk(clk), .reset(reset), .req(req), .any_decode(any_decode),
      .ack(to_ack), .timeout(to_pulse)
   );

   assign any_decode = ram_decode | uni_decode;

   // Each responder drives zero outside its own ack, so OR merges them
   assign rsp.ack   = ram_ack | uni_ack | to_ack;
   assign rsp.err   = to_ack;                  // The watchdog answers undecoded requests
   assign rsp.rdata = ram_rdata | uni_rdata;   // The watchdog returns zero

endmodule

/* sim/xbus_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Xbus slice testbench. Directed tests of the scratch RAM,
// the unibus registers, PROM disable and no-response handling
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xbus_tb import xbus_pkg::*, unibus_pkg::*;
();

   localparam int CLK_PERIOD  = 8;
   localparam int XFER_LIMIT  = TIMEOUT_CYCLES + 8;  // Cycles allowed for each ack edge
   localparam int NUM_XFERS   = 64;                  // Upper bound on transfers in the run
   localparam int WATCHDOG_NS = (NUM_XFERS * XFER_LIMIT + 200) * CLK_PERIOD;

   logic        clk = 1'b0;
   logic        reset;
   logic        req;
   xbus_req_t   cmd;
   xbus_rsp_t   rsp;
   logic        promdisable;
   logic        prom_seen;         // High if promdisable was seen in the last transfer
   logic [31:0] seed   = 32'h2bd0;
   int          errors = 0;
   int          checks = 0;

   xbus_top xbus_top_inst (
      .clk(clk), .reset(reset), .req(req), .cmd(cmd), .rsp(rsp), .promdisable(promdisable)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] next_random();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic xbus_addr_t unibus_addr(unibus_ofs_t ofs);
      return UNIBUS_BASE | xbus_addr_t'(ofs);
   endfunction

   task automatic check_word(string name, xbus_word_t got, xbus_word_t expected);
      checks++;
      if (got !== expected)
      begin
         errors++;
         $display("ERR %s: got %h expected %h", name, got, expected);
      end
   endtask

   task automatic check_flag(string name, logic got, logic expected);
      checks++;
      if (got !== expected)
      begin
         errors++;
         $display("ERR %s: got %h expected %h", name, got, expected);
      end
   endtask

   // Drives one request from a rising edge and returns on the edge after ack has fallen
   task automatic run_handshake(xbus_addr_t addr, xbus_word_t wdata, logic write,
                                output xbus_rsp_t result);
      xbus_req_t c;
      int        waited;
      c.addr    = addr;
      c.wdata   = wdata;
      c.write   = write;
      prom_seen = 1'b0;
      waited    = 0;
      req <= 1'b1;
      cmd <= c;
      do
      begin
         @(negedge clk);  // Outputs are settled mid-cycle
         waited++;
         prom_seen |= promdisable;
         result = rsp;
      end while (!result.ack && waited < XFER_LIMIT);
      if (!result.ack)
      begin
         errors++;
         $display("No ack for address %o within %0d cycles", addr, XFER_LIMIT);
      end
      @(posedge clk);
      req <= 1'b0;
      waited = 0;
      do
      begin
         @(negedge clk);
         waited++;
      end while (rsp.ack && waited < XFER_LIMIT);
      if (rsp.ack)
      begin
         errors++;
         $display("Ack stayed high after req was dropped at address %o", addr);
      end
      @(posedge clk);
   endtask

   task automatic bus_write(xbus_addr_t addr, xbus_word_t wdata, output xbus_rsp_t result);
      run_handshake(addr, wdata, 1'b1, result);
   endtask

   task automatic bus_read(xbus_addr_t addr, output xbus_rsp_t result);
      run_handshake(addr, '0, 1'b0, result);
   endtask

   task automatic ram_round_trip();
      xbus_word_t words [16];
      xbus_rsp_t  r;
      for (int i = 0; i < 16; i++)
      begin
         words[i] = next_random();
         bus_write(xbus_addr_t'(i * 17), words[i], r);
         check_flag("rsp.err", r.err, 1'b0);
      end
      for (int i = 0; i < 16; i++)
      begin
         bus_read(xbus_addr_t'(i * 17), r);
         check_word("ram rdata", r.rdata, words[i]);
         check_flag("rsp.err", r.err, 1'b0);
      end
   endtask

   task automatic int_enable_reg();
      bus_ints_t expected;
      xbus_rsp_t r;
      expected        = '0;
      expected.int_en = 1'b1;  // Only the enable survives a write of all ones
      bus_write(unibus_addr(BUS_INTS_OFS), 32'hffff_ffff, r);
      bus_read(unibus_addr(BUS_INTS_OFS), r);
      check_word("bus_ints", r.rdata, expected);
      bus_write(unibus_addr(BUS_INTS_OFS), 32'hffff_fbff, r);
      bus_read(unibus_addr(BUS_INTS_OFS), r);
      check_word("bus_ints", r.rdata, '0);
   endtask

   task automatic prom_disable_strobe();
      xbus_rsp_t r;
      bus_write(unibus_addr(PROM_CTRL_OFS), 32'h0000_0024, r);
      check_flag("promdisable", prom_seen, 1'b1);
      bus_write(unibus_addr(PROM_CTRL_OFS), 32'h0000_0001, r);
      check_flag("promdisable", prom_seen, 1'b0);
      bus_write(unibus_addr(PROM_CTRL_OFS), 32'h0000_0025, r);  // Key with bit 0 set
      check_flag("promdisable", prom_seen, 1'b0);
   endtask

   task automatic no_response_status();
      bus_status_t expected;
      xbus_rsp_t   r;
      expected = '0;
      bus_read(22'o17500000, r);
      check_flag("rsp.err", r.err, 1'b1);
      check_word("timeout rdata", r.rdata, '0);
      expected.unibus_nxm = 1'b1;
      bus_read(unibus_addr(BUS_STATUS_OFS), r);
      check_word("bus_status", r.rdata, expected);
      bus_read(22'o17200000, r);
      check_flag("rsp.err", r.err, 1'b1);
      expected.xbus_nxm = 1'b1;
      bus_read(unibus_addr(BUS_STATUS_OFS), r);
      check_word("bus_status", r.rdata, expected);
      bus_write(unibus_addr(BUS_STATUS_OFS), '0, r);
      bus_read(unibus_addr(BUS_STATUS_OFS), r);
      check_word("bus_status", r.rdata, '0);
      bus_read(22'o00400000, r);  // Below both limits
      check_flag("rsp.err", r.err, 1'b1);
      bus_read(unibus_addr(BUS_STATUS_OFS), r);
      check_word("bus_status", r.rdata, '0);
   endtask

   task automatic other_windows();
      xbus_addr_t  addrs [4];
      bus_ints_t   exp_ints;
      bus_status_t exp_status;
      xbus_rsp_t   r;
      addrs[0]              = OTHER_BASE_A | 22'o20;    // Low bits match the interrupt register
      addrs[1]              = OTHER_BASE_B | 22'o1222;  // Low bits match the status register
      addrs[2]              = unibus_addr(6'o60);
      addrs[3]              = unibus_addr(6'o62);
      exp_ints              = '0;
      exp_ints.int_en       = 1'b1;
      exp_status            = '0;
      exp_status.unibus_nxm = 1'b1;
      bus_write(unibus_addr(BUS_INTS_OFS), 32'h0000_0400, r);
      bus_read(22'o17500000, r);
      for (int i = 0; i < 4; i++)
      begin
         bus_read(addrs[i], r);
         check_flag("rsp.ack", r.ack, 1'b1);
         check_flag("rsp.err", r.err, 1'b0);
         check_word("other rdata", r.rdata, '0);
         bus_write(addrs[i], 32'h0000_0000, r);  // Would clear either register if aliased
         check_flag("rsp.err", r.err, 1'b0);
      end
      bus_read(unibus_addr(BUS_INTS_OFS), r);
      check_word("bus_ints", r.rdata, exp_ints);
      bus_read(unibus_addr(BUS_STATUS_OFS), r);
      check_word("bus_status", r.rdata, exp_status);
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("Run stopped after %0d ns without finishing the tests", WATCHDOG_NS);
      $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      reset = 1'b1;
      req   = 1'b0;
      cmd   = '0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      ram_round_trip();
      int_enable_reg();
      prom_disable_strobe();
      no_response_status();
      other_windows();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

/* flist.f */
source/xbus_pkg.sv
source/unibus_pkg.sv
source/xbus_ram.sv
source/xbus_unibus.sv
source/xbus_timeout.sv
source/xbus_top.sv
sim/xbus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the xbus testbench with Verilator, run it and search the output for the pass line
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -sv --top-module xbus_tb -f flist.f \
   && ./obj_dir/Vxbus_tb | tee /dev/stderr | grep -q "PASS: all tests" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
